// File: fsm_occupancy_decode.sv
// Decodes the four unit FSM state codes into one-hot occupancy event bits
`timescale 1ns/10ps

module fsm_occupancy_decode
  import perf_pkg::*;
(
  input  ifu_state_e     ifu_state_i,
  input  icache_state_e  icache_state_i,
  input  lsu_state_e     lsu_state_i,
  input  dcache_state_e  dcache_state_i,
  perf_event_if.state_src evt
);

  logic [2:0] ifu_oh;
  logic [3:0] ic_oh;
  logic [3:0] lsu_oh;
  logic [6:0] dc_oh;

  // Unused codes fall to default and leave the slice clear
  always_comb begin
    ifu_oh = '0;
    case (ifu_state_i)
      IFU_START:       ifu_oh[0] = 1'b1;
      IFU_WAIT_ICACHE: ifu_oh[1] = 1'b1;
      IFU_WAIT_IBUF:   ifu_oh[2] = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    ic_oh = '0;
    case (icache_state_i)
      IC_IDLE:      ic_oh[0] = 1'b1;
      IC_LOOKUP:    ic_oh[1] = 1'b1;
      IC_MISS_REQ:  ic_oh[2] = 1'b1;
      IC_MISS_WAIT: ic_oh[3] = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    lsu_oh = '0;
    case (lsu_state_i)
      LSU_IDLE:   lsu_oh[0] = 1'b1;
      LSU_LD_REQ: lsu_oh[1] = 1'b1;
      LSU_LD_RSP: lsu_oh[2] = 1'b1;
      LSU_RESP:   lsu_oh[3] = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    dc_oh = '0;
    case (dcache_state_i)
      DC_IDLE:        dc_oh[0] = 1'b1;
      DC_LOOKUP:      dc_oh[1] = 1'b1;
      DC_STORE_WRITE: dc_oh[2] = 1'b1;
      DC_WB_REQ:      dc_oh[3] = 1'b1;
      DC_MISS_REQ:    dc_oh[4] = 1'b1;
      DC_WAIT_REFILL: dc_oh[5] = 1'b1;
      DC_RESP:        dc_oh[6] = 1'b1;
      default: ;
    endcase
  end

  // Bit 0 lines up with CTR_IFU_START
  assign evt.state_evt = {dc_oh, lsu_oh, ic_oh, ifu_oh};

endmodule

// File: perf_checker.sv
// Testbench reference model that watches the DUT ports and compares every counter read
`timescale 1ns/10ps

module perf_checker
  import perf_pkg::*;
#(
  parameter int NRET  = 2,
  parameter int CNT_W = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [2:0]            test_id_i,
  input  logic [NRET-1:0]       commit_valid_i,
  input  logic                  ibuf_valid_i,
  input  logic                  ibuf_ready_i,
  input  logic                  dec_in_valid_i,
  input  logic                  dec_in_ready_i,
  input  logic                  dispatch_valid_i,
  input  logic                  rob_ready_i,
  input  logic                  issue_ready_i,
  input  logic                  alu_can_accept_i,
  input  logic                  bru_can_accept_i,
  input  logic                  lsu_can_accept_i,
  input  logic                  csr_can_accept_i,
  input  logic [SB_ALLOC_W-1:0] sb_alloc_req_i,
  input  logic                  sb_alloc_ready_i,
  input  logic                  icache_miss_valid_i,
  input  logic                  icache_miss_ready_i,
  input  logic                  dcache_miss_valid_i,
  input  logic                  dcache_miss_ready_i,
  input  logic                  flush_i,
  input  logic [1:0]            ifu_state_i,
  input  logic [1:0]            icache_state_i,
  input  logic [1:0]            lsu_state_i,
  input  logic [2:0]            dcache_state_i,
  input  logic                  clear_i,
  input  logic [CTR_ADDR_W-1:0] rd_addr_i,
  input  logic [CNT_W-1:0]      rd_data_i,
  output logic [31:0]           err_cnt_o,
  output logic [31:0]           chk_cnt_o
);

  logic [CNT_W-1:0] model [NUM_CTRS];
  logic [CNT_W-1:0] pend_exp;
  logic [CTR_ADDR_W-1:0] pend_addr;
  logic             pend_valid;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset_values";
      3'd2:    return "random_traffic";
      3'd3:    return "dispatch_priority";
      3'd4:    return "clear_with_traffic";
      3'd5:    return "read_during_counting";
      default: return "setup";
    endcase
  endfunction

  task automatic add_event(input int idx, input logic [CNT_W-1:0] amt);
    model[idx] = model[idx] + amt;
  endtask

  // One model step from the inputs seen at this edge
  task automatic step_model();
    logic any_commit;
    logic disp_ok;
    int   pc;
    any_commit = |commit_valid_i;
    disp_ok = dispatch_valid_i && rob_ready_i;
    pc = 0;
    for (int i = 0; i < NRET; i++) begin
      pc = pc + int'(commit_valid_i[i]);
    end
    add_event(CTR_CYCLES, CNT_W'(1));
    add_event(CTR_COMMIT_CYCLES, CNT_W'(any_commit));
    add_event(CTR_COMMIT_INSTRS, CNT_W'(pc));
    add_event(CTR_NOCOMMIT_CYCLES, CNT_W'(!any_commit));
    add_event(CTR_FE_EMPTY, CNT_W'(!ibuf_valid_i));
    add_event(CTR_FE_STALL, CNT_W'(ibuf_valid_i && !ibuf_ready_i));
    add_event(CTR_DEC_STALL, CNT_W'(dec_in_valid_i && !dec_in_ready_i));
    add_event(CTR_ROB_FULL, CNT_W'(dispatch_valid_i && !rob_ready_i));
    add_event(CTR_ISSUE_FULL, CNT_W'(disp_ok && !issue_ready_i));
    add_event(CTR_ALU_FULL, CNT_W'(disp_ok && !alu_can_accept_i));
    add_event(CTR_BRU_FULL, CNT_W'(disp_ok && !bru_can_accept_i));
    add_event(CTR_LSU_FULL, CNT_W'(disp_ok && !lsu_can_accept_i));
    add_event(CTR_CSR_FULL, CNT_W'(disp_ok && !csr_can_accept_i));
    add_event(CTR_SB_FULL, CNT_W'((|sb_alloc_req_i) && !sb_alloc_ready_i));
    add_event(CTR_ICACHE_MISS_CYCLES, CNT_W'(icache_miss_valid_i && !icache_miss_ready_i));
    add_event(CTR_DCACHE_MISS_CYCLES, CNT_W'(dcache_miss_valid_i && !dcache_miss_ready_i));
    add_event(CTR_FLUSH, CNT_W'(flush_i));
    add_event(CTR_ICACHE_MISS_REQS, CNT_W'(icache_miss_valid_i));
    add_event(CTR_DCACHE_MISS_REQS, CNT_W'(dcache_miss_valid_i));
    // Unused codes 3 and 7 count nowhere
    if (ifu_state_i != 2'd3) begin
      add_event(int'(CTR_IFU_START) + int'(ifu_state_i), CNT_W'(1));
    end
    add_event(int'(CTR_IC_IDLE) + int'(icache_state_i), CNT_W'(1));
    add_event(int'(CTR_LSU_IDLE) + int'(lsu_state_i), CNT_W'(1));
    if (dcache_state_i != 3'd7) begin
      add_event(int'(CTR_DC_IDLE) + int'(dcache_state_i), CNT_W'(1));
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        model[i] = '0;
      end
      // Read data must still be zero at the first edge out of reset
      pend_valid = 1'b1;
      pend_exp   = '0;
      pend_addr  = '0;
      err_cnt_o  = '0;
      chk_cnt_o  = '0;
    end else begin
      // rd_data still holds the answer to the address of the last edge
      if (pend_valid) begin
        chk_cnt_o = chk_cnt_o + 1;
        if (rd_data_i !== pend_exp) begin
          err_cnt_o = err_cnt_o + 1;
          $display("[FAIL] %s: counter %0d expected %0h actual %0h",
                   test_name(test_id_i), pend_addr, pend_exp, rd_data_i);
        end
      end
      pend_addr  = rd_addr_i;
      pend_exp   = (int'(rd_addr_i) < NUM_CTRS) ? model[rd_addr_i] : '0;
      pend_valid = 1'b1;
      if (clear_i) begin
        for (int i = 0; i < NUM_CTRS; i++) begin
          model[i] = '0;
        end
      end else begin
        step_model();
      end
    end
  end

endmodule

// File: perf_counter_bank.sv
// Counter registers with per-event increment, global clear and a registered read port
`timescale 1ns/10ps

module perf_counter_bank
  import perf_pkg::*;
#(
  parameter int NRET  = 2,
  parameter int CNT_W = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  perf_event_if.sink            evt,
  input  logic [CTR_ADDR_W-1:0] rd_addr_i,
  output logic [CNT_W-1:0]      rd_data_o
);

  localparam int CW = $clog2(NRET + 1);

  logic [CNT_W-1:0] ctr_q [NUM_CTRS];
  logic [CNT_W-1:0] inc   [NUM_CTRS];
  logic [CW-1:0]    commit_cnt;
  logic [CNT_W-1:0] rd_sel;

  assign commit_cnt = evt.commit_count;

  always_comb begin
    for (int i = 0; i < NUM_CTRS; i++) begin
      inc[i] = '0;
    end
    inc[CTR_CYCLES]        = CNT_W'(1);
    inc[CTR_COMMIT_CYCLES] = CNT_W'(evt.commit_any);
    inc[CTR_COMMIT_INSTRS] = CNT_W'(commit_cnt);
    for (int i = 0; i < NUM_STALL_EVT; i++) begin
      inc[STALL_EVT_BASE + i] = CNT_W'(evt.stall_evt[i]);
    end
    for (int i = 0; i < NUM_STATE_EVT; i++) begin
      inc[STATE_EVT_BASE + i] = CNT_W'(evt.state_evt[i]);
    end
  end

  // Clear wins over that cycle's increments, sums wrap at CNT_W bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= '0;
      end
    end else if (clear_i) begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CTRS; i++) begin
        ctr_q[i] <= ctr_q[i] + inc[i];
      end
    end
  end

  // Unmapped addresses read as zero
  always_comb begin
    rd_sel = '0;
    for (int i = 0; i < NUM_CTRS; i++) begin
      if (rd_addr_i == CTR_ADDR_W'(i)) begin
        rd_sel = ctr_q[i];
      end
    end
  end

  // Read data shows the value from before the sampling edge
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_o <= '0;
    end else begin
      rd_data_o <= rd_sel;
    end
  end

endmodule

// File: perf_event_if.sv
// Per-cycle event levels passed from the event decoders to the counter bank
`timescale 1ns/10ps

interface perf_event_if
  import perf_pkg::*;
#(
  parameter int NRET = 2
);

  localparam int CW = $clog2(NRET + 1);

  logic [NUM_STALL_EVT-1:0] stall_evt;
  logic                     commit_any;
  logic [CW-1:0]            commit_count;
  logic [NUM_STATE_EVT-1:0] state_evt;

  modport pipe_src (
    output stall_evt,
    output commit_any,
    output commit_count
  );

  modport state_src (output state_evt);

  modport sink (input stall_evt, input commit_any, input commit_count, input state_evt);

endinterface

// File: perf_monitor.f
perf_pkg.sv
perf_event_if.sv
pipe_event_decode.sv
fsm_occupancy_decode.sv
perf_counter_bank.sv
perf_monitor.sv
tb_clk_gen.sv
perf_checker.sv
tb_perf_monitor.sv

// File: perf_monitor.sv
// Top level of the performance monitor; takes core status levels and serves counter reads
`timescale 1ns/10ps

module perf_monitor
  import perf_pkg::*;
#(
  parameter int NRET  = 2,
  parameter int CNT_W = 64
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [NRET-1:0]       commit_valid_i,
  input  logic                  ibuf_valid_i,
  input  logic                  ibuf_ready_i,
  input  logic                  dec_in_valid_i,
  input  logic                  dec_in_ready_i,
  input  logic                  dispatch_valid_i,
  input  logic                  rob_ready_i,
  input  logic                  issue_ready_i,
  input  logic                  alu_can_accept_i,
  input  logic                  bru_can_accept_i,
  input  logic                  lsu_can_accept_i,
  input  logic                  csr_can_accept_i,
  input  logic [SB_ALLOC_W-1:0] sb_alloc_req_i,
  input  logic                  sb_alloc_ready_i,
  input  logic                  icache_miss_valid_i,
  input  logic                  icache_miss_ready_i,
  input  logic                  dcache_miss_valid_i,
  input  logic                  dcache_miss_ready_i,
  input  logic                  flush_i,
  input  ifu_state_e            ifu_state_i,
  input  icache_state_e         icache_state_i,
  input  lsu_state_e            lsu_state_i,
  input  dcache_state_e         dcache_state_i,
  input  logic                  clear_i,
  input  logic [CTR_ADDR_W-1:0] rd_addr_i,
  output logic [CNT_W-1:0]      rd_data_o
);

  perf_event_if #(.NRET(NRET)) evt_if ();

  pipe_event_decode #(
    .NRET(NRET)
  ) u_pipe_dec (
    .commit_valid_i,
    .ibuf_valid_i,
    .ibuf_ready_i,
    .dec_in_valid_i,
    .dec_in_ready_i,
    .dispatch_valid_i,
    .rob_ready_i,
    .issue_ready_i,
    .alu_can_accept_i,
    .bru_can_accept_i,
    .lsu_can_accept_i,
    .csr_can_accept_i,
    .sb_alloc_req_i,
    .sb_alloc_ready_i,
    .icache_miss_valid_i,
    .icache_miss_ready_i,
    .dcache_miss_valid_i,
    .dcache_miss_ready_i,
    .flush_i,
    .evt (evt_if.pipe_src)
  );

  fsm_occupancy_decode u_occ_dec (
    .ifu_state_i,
    .icache_state_i,
    .lsu_state_i,
    .dcache_state_i,
    .evt (evt_if.state_src)
  );

  perf_counter_bank #(
    .NRET  (NRET),
    .CNT_W (CNT_W)
  ) u_bank (
    .clk_i,
    .rst_ni,
    .clear_i,
    .evt (evt_if.sink),
    .rd_addr_i,
    .rd_data_o
  );

endmodule

// File: perf_pkg.sv
// Shared state encodings, counter IDs and widths for the performance monitor
package perf_pkg;

  // Fetch unit states, code 3 unused
  typedef enum logic [1:0] {
    IFU_START       = 2'd0,
    IFU_WAIT_ICACHE = 2'd1,
    IFU_WAIT_IBUF   = 2'd2
  } ifu_state_e;

  typedef enum logic [1:0] {
    IC_IDLE      = 2'd0,
    IC_LOOKUP    = 2'd1,
    IC_MISS_REQ  = 2'd2,
    IC_MISS_WAIT = 2'd3
  } icache_state_e;

  typedef enum logic [1:0] {
    LSU_IDLE   = 2'd0,
    LSU_LD_REQ = 2'd1,
    LSU_LD_RSP = 2'd2,
    LSU_RESP   = 2'd3
  } lsu_state_e;

  // Code 7 unused
  typedef enum logic [2:0] {
    DC_IDLE        = 3'd0,
    DC_LOOKUP      = 3'd1,
    DC_STORE_WRITE = 3'd2,
    DC_WB_REQ      = 3'd3,
    DC_MISS_REQ    = 3'd4,
    DC_WAIT_REFILL = 3'd5,
    DC_RESP        = 3'd6
  } dcache_state_e;

  // Counter IDs, the value is the read address
  typedef enum logic [5:0] {
    CTR_CYCLES, CTR_COMMIT_CYCLES, CTR_COMMIT_INSTRS, CTR_NOCOMMIT_CYCLES,
    CTR_FE_EMPTY, CTR_FE_STALL, CTR_DEC_STALL, CTR_ROB_FULL, CTR_ISSUE_FULL,
    CTR_ALU_FULL, CTR_BRU_FULL, CTR_LSU_FULL, CTR_CSR_FULL, CTR_SB_FULL,
    CTR_ICACHE_MISS_CYCLES, CTR_DCACHE_MISS_CYCLES, CTR_FLUSH,
    CTR_ICACHE_MISS_REQS, CTR_DCACHE_MISS_REQS,
    CTR_IFU_START, CTR_IFU_WAIT_ICACHE, CTR_IFU_WAIT_IBUF,
    CTR_IC_IDLE, CTR_IC_LOOKUP, CTR_IC_MISS_REQ, CTR_IC_MISS_WAIT,
    CTR_LSU_IDLE, CTR_LSU_LD_REQ, CTR_LSU_LD_RSP, CTR_LSU_RESP,
    CTR_DC_IDLE, CTR_DC_LOOKUP, CTR_DC_STORE_WRITE, CTR_DC_WB_REQ,
    CTR_DC_MISS_REQ, CTR_DC_WAIT_REFILL, CTR_DC_RESP
  } perf_ctr_e;

  localparam int NUM_CTRS   = 37;
  localparam int CTR_ADDR_W = 6;

  // Pipeline event bits cover NOCOMMIT_CYCLES up to DCACHE_MISS_REQS,
  // commit cycles travel as commit_any
  localparam int NUM_STALL_EVT  = 16;
  localparam int STALL_EVT_BASE = 3;

  // Occupancy bits cover IFU_START up to DC_RESP
  localparam int NUM_STATE_EVT  = 18;
  localparam int STATE_EVT_BASE = 19;

  localparam int SB_ALLOC_W = 4;

endpackage

// File: pipe_event_decode.sv
// Decodes core pipeline status levels into stall/miss event bits and the commit count
`timescale 1ns/10ps

module pipe_event_decode
  import perf_pkg::*;
#(
  parameter int NRET = 2
) (
  input  logic [NRET-1:0]       commit_valid_i,
  input  logic                  ibuf_valid_i,
  input  logic                  ibuf_ready_i,
  input  logic                  dec_in_valid_i,
  input  logic                  dec_in_ready_i,
  input  logic                  dispatch_valid_i,
  input  logic                  rob_ready_i,
  input  logic                  issue_ready_i,
  input  logic                  alu_can_accept_i,
  input  logic                  bru_can_accept_i,
  input  logic                  lsu_can_accept_i,
  input  logic                  csr_can_accept_i,
  input  logic [SB_ALLOC_W-1:0] sb_alloc_req_i,
  input  logic                  sb_alloc_ready_i,
  input  logic                  icache_miss_valid_i,
  input  logic                  icache_miss_ready_i,
  input  logic                  dcache_miss_valid_i,
  input  logic                  dcache_miss_ready_i,
  input  logic                  flush_i,
  perf_event_if.pipe_src        evt
);

  localparam int CW = $clog2(NRET + 1);
  localparam int B  = STALL_EVT_BASE;

  logic                     commit_any;
  logic                     disp_ok;
  logic [CW-1:0]            commit_cnt;
  logic [NUM_STALL_EVT-1:0] stall;

  assign commit_any = |commit_valid_i;

  // Unit-full events only count once the ROB has accepted
  assign disp_ok = dispatch_valid_i && rob_ready_i;

  always_comb begin
    commit_cnt = '0;
    for (int i = 0; i < NRET; i++) begin
      commit_cnt = commit_cnt + CW'(commit_valid_i[i]);
    end
  end

  always_comb begin
    stall = '0;
    stall[CTR_NOCOMMIT_CYCLES - B]    = !commit_any;
    stall[CTR_FE_EMPTY - B]           = !ibuf_valid_i;
    stall[CTR_FE_STALL - B]           = ibuf_valid_i && !ibuf_ready_i;
    stall[CTR_DEC_STALL - B]          = dec_in_valid_i && !dec_in_ready_i;
    stall[CTR_ROB_FULL - B]           = dispatch_valid_i && !rob_ready_i;
    stall[CTR_ISSUE_FULL - B]         = disp_ok && !issue_ready_i;
    stall[CTR_ALU_FULL - B]           = disp_ok && !alu_can_accept_i;
    stall[CTR_BRU_FULL - B]           = disp_ok && !bru_can_accept_i;
    stall[CTR_LSU_FULL - B]           = disp_ok && !lsu_can_accept_i;
    stall[CTR_CSR_FULL - B]           = disp_ok && !csr_can_accept_i;
    stall[CTR_SB_FULL - B]            = (|sb_alloc_req_i) && !sb_alloc_ready_i;
    stall[CTR_ICACHE_MISS_CYCLES - B] = icache_miss_valid_i && !icache_miss_ready_i;
    stall[CTR_DCACHE_MISS_CYCLES - B] = dcache_miss_valid_i && !dcache_miss_ready_i;
    stall[CTR_FLUSH - B]              = flush_i;
    // Requests count whether or not the memory side is ready
    stall[CTR_ICACHE_MISS_REQS - B]   = icache_miss_valid_i;
    stall[CTR_DCACHE_MISS_REQS - B]   = dcache_miss_valid_i;
  end

  assign evt.stall_evt    = stall;
  assign evt.commit_any   = commit_any;
  assign evt.commit_count = commit_cnt;

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_perf_monitor \
  -f perf_monitor.f -o tb_perf_monitor_sim || exit 1

sim_out=$(./obj_dir/tb_perf_monitor_sim)
echo "$sim_out"

echo "$sim_out" | grep -q "^Regression passed$" && exit 0 || exit 1

// File: tb_clk_gen.sv
// Testbench clock and reset source, 40 ns period with reset held low for 16 cycles
`timescale 1ns/10ps

module tb_clk_gen #(
  parameter int RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #20 clk_o = ~clk_o;
    end
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: tb_perf_monitor.sv
// Testbench top that drives LCG traffic and read sweeps into the performance monitor
`timescale 1ns/10ps

module tb_perf_monitor;
  import perf_pkg::*;

  localparam int NRET  = 2;
  localparam int CNT_W = 64;
  localparam int MAX_CYCLES = 10000;

  logic clk;
  logic rst_n;
  logic [2:0] test_id;
  logic [NRET-1:0] commit_valid;
  logic ibuf_valid, ibuf_ready, dec_in_valid, dec_in_ready;
  logic dispatch_valid, rob_ready, issue_ready;
  logic alu_can_accept, bru_can_accept, lsu_can_accept, csr_can_accept;
  logic [SB_ALLOC_W-1:0] sb_alloc_req;
  logic sb_alloc_ready, icache_miss_valid, icache_miss_ready;
  logic dcache_miss_valid, dcache_miss_ready, flush, clear;
  ifu_state_e ifu_state;
  icache_state_e icache_state;
  lsu_state_e lsu_state;
  dcache_state_e dcache_state;
  logic [CTR_ADDR_W-1:0] rd_addr;
  logic [CNT_W-1:0] rd_data;
  logic [31:0] chk_errs;
  logic [31:0] chk_checks;
  logic [31:0] lcg_state = 32'h820b827a;
  int tb_errs = 0;
  int tb_checks = 0;

  tb_clk_gen #(.RST_CYCLES(16)) u_clk (.clk_o(clk), .rst_no(rst_n));

  perf_monitor #(.NRET(NRET), .CNT_W(CNT_W)) UUT (
    .clk_i(clk), .rst_ni(rst_n), .commit_valid_i(commit_valid),
    .ibuf_valid_i(ibuf_valid), .ibuf_ready_i(ibuf_ready),
    .dec_in_valid_i(dec_in_valid), .dec_in_ready_i(dec_in_ready),
    .dispatch_valid_i(dispatch_valid), .rob_ready_i(rob_ready),
    .issue_ready_i(issue_ready), .alu_can_accept_i(alu_can_accept),
    .bru_can_accept_i(bru_can_accept), .lsu_can_accept_i(lsu_can_accept),
    .csr_can_accept_i(csr_can_accept), .sb_alloc_req_i(sb_alloc_req),
    .sb_alloc_ready_i(sb_alloc_ready), .icache_miss_valid_i(icache_miss_valid),
    .icache_miss_ready_i(icache_miss_ready), .dcache_miss_valid_i(dcache_miss_valid),
    .dcache_miss_ready_i(dcache_miss_ready), .flush_i(flush),
    .ifu_state_i(ifu_state), .icache_state_i(icache_state),
    .lsu_state_i(lsu_state), .dcache_state_i(dcache_state),
    .clear_i(clear), .rd_addr_i(rd_addr), .rd_data_o(rd_data)
  );

  perf_checker #(.NRET(NRET), .CNT_W(CNT_W)) u_chk (
    .clk_i(clk), .rst_ni(rst_n), .test_id_i(test_id), .commit_valid_i(commit_valid),
    .ibuf_valid_i(ibuf_valid), .ibuf_ready_i(ibuf_ready),
    .dec_in_valid_i(dec_in_valid), .dec_in_ready_i(dec_in_ready),
    .dispatch_valid_i(dispatch_valid), .rob_ready_i(rob_ready),
    .issue_ready_i(issue_ready), .alu_can_accept_i(alu_can_accept),
    .bru_can_accept_i(bru_can_accept), .lsu_can_accept_i(lsu_can_accept),
    .csr_can_accept_i(csr_can_accept), .sb_alloc_req_i(sb_alloc_req),
    .sb_alloc_ready_i(sb_alloc_ready), .icache_miss_valid_i(icache_miss_valid),
    .icache_miss_ready_i(icache_miss_ready), .dcache_miss_valid_i(dcache_miss_valid),
    .dcache_miss_ready_i(dcache_miss_ready), .flush_i(flush),
    .ifu_state_i(ifu_state), .icache_state_i(icache_state),
    .lsu_state_i(lsu_state), .dcache_state_i(dcache_state),
    .clear_i(clear), .rd_addr_i(rd_addr), .rd_data_i(rd_data),
    .err_cnt_o(chk_errs), .chk_cnt_o(chk_checks)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Called right after a rising edge and uses only the upper LCG bits
  task automatic drive_random();
    logic [31:0] a;
    logic [31:0] b;
    a = lcg_next();
    b = lcg_next();
    commit_valid <= a[31:30];
    ibuf_valid <= a[29];
    ibuf_ready <= a[28];
    dec_in_valid <= a[27];
    dec_in_ready <= a[26];
    dispatch_valid <= a[25];
    rob_ready <= a[24];
    issue_ready <= a[23];
    alu_can_accept <= a[22];
    bru_can_accept <= a[21];
    lsu_can_accept <= a[20];
    csr_can_accept <= a[19];
    sb_alloc_req <= a[18:15];
    sb_alloc_ready <= a[14];
    icache_miss_valid <= a[13];
    icache_miss_ready <= a[12];
    dcache_miss_valid <= b[31];
    dcache_miss_ready <= b[30];
    flush <= b[29];
    ifu_state <= ifu_state_e'(b[28:27]);
    icache_state <= icache_state_e'(b[26:25]);
    lsu_state <= lsu_state_e'(b[24:23]);
    dcache_state <= dcache_state_e'(b[22:20]);
  endtask

  task automatic drive_idle();
    commit_valid <= '0;
    {ibuf_valid, ibuf_ready, dec_in_valid, dec_in_ready} <= 4'b0;
    {dispatch_valid, rob_ready, issue_ready} <= 3'b0;
    {alu_can_accept, bru_can_accept, lsu_can_accept, csr_can_accept} <= 4'b0;
    sb_alloc_req <= '0;
    {sb_alloc_ready, icache_miss_valid, icache_miss_ready} <= 3'b0;
    {dcache_miss_valid, dcache_miss_ready, flush} <= 3'b0;
    ifu_state <= IFU_START;
    icache_state <= IC_IDLE;
    lsu_state <= LSU_IDLE;
    dcache_state <= DC_IDLE;
  endtask

  task automatic random_cycles(input int n, input logic rand_addr);
    for (int i = 0; i < n; i++) begin
      @(posedge clk);
      drive_random();
      if (rand_addr) begin
        rd_addr <= CTR_ADDR_W'(lcg_next() >> 26);
      end
    end
  endtask

  // Reads every address once plus two edges for the last response
  task automatic sweep_all(input logic traffic);
    for (int a = 0; a < 64; a++) begin
      @(posedge clk);
      rd_addr <= CTR_ADDR_W'(a);
      if (traffic) begin
        drive_random();
      end
    end
    @(posedge clk);
    drive_idle();
    @(posedge clk);
  endtask

  task automatic read_counter(input perf_ctr_e id, output logic [CNT_W-1:0] val);
    @(posedge clk);
    rd_addr <= id;
    @(posedge clk);
    @(negedge clk);
    val = rd_data;
  endtask

  task automatic check_value(input string name, input logic [CNT_W-1:0] exp,
                             input logic [CNT_W-1:0] act);
    tb_checks++;
    if (act !== exp) begin
      tb_errs++;
      $display("[FAIL] %s: expected %0d actual %0d", name, exp, act);
    end
  endtask

  // Counts are read after the checker has finished the last edge
  task automatic end_test(input string name, input int errs_before);
    int errs;
    @(negedge clk);
    errs = int'(chk_errs) + tb_errs - errs_before;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  // Dispatch with ROB stalled must only count ROB_FULL
  task automatic dispatch_priority();
    logic [CNT_W-1:0] base [6];
    logic [CNT_W-1:0] now;
    perf_ctr_e ids [6];
    ids = '{CTR_ROB_FULL, CTR_ISSUE_FULL, CTR_ALU_FULL, CTR_BRU_FULL, CTR_LSU_FULL,
            CTR_CSR_FULL};
    @(posedge clk);
    drive_idle();
    for (int i = 0; i < 6; i++) begin
      read_counter(ids[i], base[i]);
    end
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      dispatch_valid <= 1'b1;
      rob_ready <= 1'b0;
    end
    @(posedge clk);
    drive_idle();
    for (int i = 0; i < 6; i++) begin
      read_counter(ids[i], now);
      check_value("dispatch_priority", (i == 0) ? base[i] + CNT_W'(12) : base[i], now);
    end
  endtask

  task automatic run_tests();
    int start;
    test_id <= 3'd1;
    start = 0;
    sweep_all(1'b0);
    end_test("reset_values", start);

    start = int'(chk_errs) + tb_errs;
    test_id <= 3'd2;
    random_cycles(2000, 1'b1);
    sweep_all(1'b0);
    end_test("random_traffic", start);

    start = int'(chk_errs) + tb_errs;
    test_id <= 3'd3;
    dispatch_priority();
    end_test("dispatch_priority", start);

    start = int'(chk_errs) + tb_errs;
    test_id <= 3'd4;
    random_cycles(200, 1'b1);
    @(posedge clk);
    drive_random();
    clear <= 1'b1;
    @(posedge clk);
    drive_random();
    clear <= 1'b0;
    random_cycles(50, 1'b1);
    sweep_all(1'b1);
    end_test("clear_with_traffic", start);

    start = int'(chk_errs) + tb_errs;
    test_id <= 3'd5;
    random_cycles(500, 1'b1);
    sweep_all(1'b1);
    end_test("read_during_counting", start);
  endtask

  initial begin
    int n;
    int total;
    test_id = 3'd0;
    clear = 1'b0;
    rd_addr = '0;
    commit_valid = '0;
    {ibuf_valid, ibuf_ready, dec_in_valid, dec_in_ready} = 4'b0;
    {dispatch_valid, rob_ready, issue_ready} = 3'b0;
    {alu_can_accept, bru_can_accept, lsu_can_accept, csr_can_accept} = 4'b0;
    sb_alloc_req = '0;
    {sb_alloc_ready, icache_miss_valid, icache_miss_ready} = 3'b0;
    {dcache_miss_valid, dcache_miss_ready, flush} = 3'b0;
    ifu_state = IFU_START;
    icache_state = IC_IDLE;
    lsu_state = LSU_IDLE;
    dcache_state = DC_IDLE;

    n = 0;
    while (rst_n !== 1'b1 && n < 100) begin
      @(posedge clk);
      n++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      $display("Regression failed");
    end else begin
      run_tests();
      total = int'(chk_errs) + tb_errs;
      $display("checks %0d, errors %0d", int'(chk_checks) + tb_checks, total);
      if (total == 0) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
    end
    $finish;
  end

  initial begin : watchdog
    int cyc;
    cyc = 0;
    while (cyc < MAX_CYCLES) begin
      @(posedge clk);
      cyc++;
    end
    $display("Simulation timed out after %0d cycles", MAX_CYCLES);
    $display("Regression failed");
    $finish;
  end

endmodule
